/* compile.f */
+incdir+design
design/spike_delay_pkg.sv
design/host_cmd_decoder.sv
design/sim_tick_gen.sv
design/spike_counter.sv
design/count_delay_stage.sv
design/count_history_tap.sv
design/spike_delay_top.sv
dv/spike_delay_assertions.sv
dv/spike_delay_tb.sv

/* design/count_delay_stage.sv */
module count_delay_stage
#(
    parameter type data_t = spike_delay_pkg::count_t
)
(
    input  logic   ep50trig,
    input  logic   reset_global,
    input  logic   i_shift,
    input  logic   i_sim_clear,
    input  data_t  i_count,
    input  logic   i_valid,
    output data_t  o_count,
    output logic   o_valid
);

    // one history slot, count and valid move together
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_count <= '0;
            o_valid <= 1'b0;
        end
        else if (i_sim_clear)
        begin
            // history wiped, slot empty again
            o_count <= '0;
            o_valid <= 1'b0;
        end
        else if (i_shift)
        begin
            o_count <= i_count;
            o_valid <= i_valid;
        end
    end

endmodule

/* design/count_history_tap.sv */
module count_history_tap
(
    input  logic                     ep50trig,
    input  logic                     reset_global,
    input  logic                     i_count_strobe,
    input  logic                     i_sim_clear,
    input  spike_delay_pkg::count_t  i_count_now,
    input  spike_delay_pkg::count_t  i_last_count,
    input  logic                     i_last_valid,
    output spike_delay_pkg::count_t  o_count_now,
    output spike_delay_pkg::count_t  o_count_delayed,
    output logic                     o_delayed_valid,
    output logic                     o_sample_strobe
);

    //////////////////////////////
    // sample register
    //////////////////////////////

    // chain end is read on the same edge it shifts,
    // so the value taken is the pre-shift one
    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_count_now     <= '0;
            o_count_delayed <= '0;
            o_delayed_valid <= 1'b0;
            o_sample_strobe <= 1'b0;
        end
        else if (i_sim_clear)
        begin
            o_count_now     <= '0;
            o_count_delayed <= '0;
            o_delayed_valid <= 1'b0;
            o_sample_strobe <= 1'b0;
        end
        else if (i_count_strobe)
        begin
            o_count_now     <= i_count_now;
            // empty slot reads as zero
            o_count_delayed <= i_last_valid ? i_last_count : '0;
            o_delayed_valid <= i_last_valid;
            o_sample_strobe <= 1'b1;
        end
        else
        begin
            o_sample_strobe <= 1'b0;
        end
    end

endmodule

/* design/host_cmd_decoder.sv */
`include "spike_delay_macros.svh"

module host_cmd_decoder
(
    input  logic                       ep50trig,
    input  logic                       reset_global,
    input  logic                       i_cmd_strobe,
    input  spike_delay_pkg::cmd_op_t   i_cmd_op,
    input  spike_delay_pkg::half_t     i_cmd_data,
    output spike_delay_pkg::half_t     o_tick_half,
    output logic                       o_sim_clear
);

    // clamped copy of the command data
    spike_delay_pkg::half_t load_value;

    // floor at the smallest legal half-count
    always_comb
    begin
        if (i_cmd_data < spike_delay_pkg::half_t'(`SPK_HALF_MIN))
        begin
            load_value = spike_delay_pkg::half_t'(`SPK_HALF_MIN);
        end
        else
        begin
            load_value = i_cmd_data;
        end
    end

    //////////////////////////////
    // command register
    //////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            o_tick_half <= spike_delay_pkg::half_t'(`SPK_HALF_DEFAULT);
            o_sim_clear <= 1'b0;
        end
        else
        begin
            // clear is a single cycle pulse
            o_sim_clear <= 1'b0;
            if (i_cmd_strobe)
            begin
                case (i_cmd_op)
                    spike_delay_pkg::CMD_LOAD_HALF:
                    begin
                        // tick gen picks this up at its next wrap
                        o_tick_half <= load_value;
                    end
                    spike_delay_pkg::CMD_SIM_RESET:
                    begin
                        // half-count kept across a sim reset
                        o_sim_clear <= 1'b1;
                    end
                    default:
                    begin
                        // nop and unused codes
                        o_sim_clear <= 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

/* design/sim_tick_gen.sv */
`include "spike_delay_macros.svh"

module sim_tick_gen
(
    input  logic                    ep50trig,
    input  logic                    reset_global,
    input  spike_delay_pkg::half_t  i_tick_half,
    input  logic                    i_sim_clear,
    output logic                    o_tick
);

    // position inside the current interval
    spike_delay_pkg::half_t tick_cnt;
    // half-count in force for this interval
    spike_delay_pkg::half_t cur_half;

    // interval end reached
    logic wrap;

    assign wrap = (tick_cnt == cur_half);

    //////////////////////////////
    // interval counter
    //////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            tick_cnt <= '0;
            cur_half <= spike_delay_pkg::half_t'(`SPK_HALF_DEFAULT);
            o_tick   <= 1'b0;
        end
        else if (i_sim_clear)
        begin
            // restart interval with held half-count untouched
            tick_cnt <= '0;
            o_tick   <= 1'b0;
        end
        else if (wrap)
        begin
            tick_cnt <= '0;
            o_tick   <= 1'b1;
            // new load only takes effect here
            cur_half <= i_tick_half;
        end
        else
        begin
            tick_cnt <= tick_cnt + 1'b1;
            o_tick   <= 1'b0;
        end
    end

endmodule

/* design/spike_counter.sv */
module spike_counter
(
    input  logic                     ep50trig,
    input  logic                     reset_global,
    input  logic                     i_spike,
    input  logic                     i_tick,
    input  logic                     i_sim_clear,
    output spike_delay_pkg::count_t  o_count,
    output logic                     o_count_strobe
);

    // two stage synchronizer plus edge history
    logic spike_meta;
    logic spike_sync;
    logic spike_prev;

    // rising edge of the synced spike
    logic spike_edge;

    // running total for the open interval
    spike_delay_pkg::count_t acc;

    //////////////////////////////
    // input sync
    //////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            spike_meta <= 1'b0;
            spike_sync <= 1'b0;
            spike_prev <= 1'b0;
        end
        else
        begin
            spike_meta <= i_spike;
            spike_sync <= spike_meta;
            spike_prev <= spike_sync;
        end
    end

    assign spike_edge = spike_sync & ~spike_prev;

    //////////////////////////////
    // edge accumulator
    //////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            acc            <= '0;
            o_count        <= '0;
            o_count_strobe <= 1'b0;
        end
        else if (i_sim_clear)
        begin
            acc            <= '0;
            o_count        <= '0;
            o_count_strobe <= 1'b0;
        end
        else if (i_tick)
        begin
            // edge on the tick cycle closes into this interval
            o_count        <= acc + spike_delay_pkg::count_t'(spike_edge);
            acc            <= '0;
            o_count_strobe <= 1'b1;
        end
        else
        begin
            acc            <= acc + spike_delay_pkg::count_t'(spike_edge);
            o_count_strobe <= 1'b0;
        end
    end

endmodule

/* design/spike_delay_macros.svh */
`ifndef SPIKE_DELAY_MACROS_SVH
`define SPIKE_DELAY_MACROS_SVH

//////////////////////////////
// data path widths
//////////////////////////////

// one interval spike count
`define SPK_COUNT_W 32

// tick half-count, same width as host command data
`define SPK_HALF_W 16

//////////////////////////////
// history and tick defaults
//////////////////////////////

// number of delay stages in the history chain
`define SPK_HIST_DEPTH 31

// half-count after reset, 10 cycle interval
`define SPK_HALF_DEFAULT 9

// loads below this are raised to it
`define SPK_HALF_MIN 3

`endif

/* design/spike_delay_pkg.sv */
`include "spike_delay_macros.svh"

package spike_delay_pkg;

    //////////////////////////////
    // host command opcodes
    //////////////////////////////

    // nop is decoded and dropped
    typedef enum logic [1:0]
    {
        CMD_NOP       = 2'd0,
        CMD_LOAD_HALF = 2'd1,
        CMD_SIM_RESET = 2'd2
    } cmd_op_t;

    //////////////////////////////
    // payload types
    //////////////////////////////

    // spikes seen in one simulation interval
    typedef logic [`SPK_COUNT_W-1:0] count_t;

    // tick half-count, interval is half + 1 cycles
    typedef logic [`SPK_HALF_W-1:0] half_t;

endpackage

/* design/spike_delay_top.sv */
`include "spike_delay_macros.svh"

module spike_delay_top
(
    input  logic                       ep50trig,
    input  logic                       reset_global,
    input  logic                       i_cmd_strobe,
    input  spike_delay_pkg::cmd_op_t   i_cmd_op,
    input  spike_delay_pkg::half_t     i_cmd_data,
    input  logic                       i_spike,
    output spike_delay_pkg::count_t    o_count_now,
    output spike_delay_pkg::count_t    o_count_delayed,
    output logic                       o_delayed_valid,
    output logic                       o_sample_strobe
);

    // decoder outputs
    spike_delay_pkg::half_t  tick_half;
    logic                    sim_clear;

    // interval tick
    logic                    tick;

    // per interval count and its strobe
    spike_delay_pkg::count_t count_value;
    logic                    count_strobe;

    // history chain, index 0 is the chain input
    spike_delay_pkg::count_t chain_count [0:`SPK_HIST_DEPTH];
    logic                    chain_valid [0:`SPK_HIST_DEPTH];

    //////////////////////////////
    // control path
    //////////////////////////////

    host_cmd_decoder u_host_cmd_decoder
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_cmd_strobe (i_cmd_strobe),
        .i_cmd_op     (i_cmd_op),
        .i_cmd_data   (i_cmd_data),
        .o_tick_half  (tick_half),
        .o_sim_clear  (sim_clear)
    );

    sim_tick_gen u_sim_tick_gen
    (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_tick_half  (tick_half),
        .i_sim_clear  (sim_clear),
        .o_tick       (tick)
    );

    spike_counter u_spike_counter
    (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .i_spike        (i_spike),
        .i_tick         (tick),
        .i_sim_clear    (sim_clear),
        .o_count        (count_value),
        .o_count_strobe (count_strobe)
    );

    //////////////////////////////
    // history chain
    //////////////////////////////

    // every new count enters as a valid entry
    assign chain_count[0] = count_value;
    assign chain_valid[0] = 1'b1;

    genvar k;
    generate
        for (k = 0; k < `SPK_HIST_DEPTH; k++)
        begin : g_stage
            count_delay_stage #(.data_t(spike_delay_pkg::count_t)) u_stage
            (
                .ep50trig     (ep50trig),
                .reset_global (reset_global),
                .i_shift      (count_strobe),
                .i_sim_clear  (sim_clear),
                .i_count      (chain_count[k]),
                .i_valid      (chain_valid[k]),
                .o_count      (chain_count[k+1]),
                .o_valid      (chain_valid[k+1])
            );
        end
    endgenerate

    // output tap at the end of the chain
    count_history_tap u_count_history_tap
    (
        .ep50trig        (ep50trig),
        .reset_global    (reset_global),
        .i_count_strobe  (count_strobe),
        .i_sim_clear     (sim_clear),
        .i_count_now     (count_value),
        .i_last_count    (chain_count[`SPK_HIST_DEPTH]),
        .i_last_valid    (chain_valid[`SPK_HIST_DEPTH]),
        .o_count_now     (o_count_now),
        .o_count_delayed (o_count_delayed),
        .o_delayed_valid (o_delayed_valid),
        .o_sample_strobe (o_sample_strobe)
    );

endmodule

/* dv/spike_delay_assertions.sv */
module spike_delay_assertions
(
    input  logic                     ep50trig,
    input  logic                     reset_global,
    input  logic                     i_sim_clear,
    input  logic                     i_tick,
    input  logic                     i_count_strobe,
    input  logic                     i_sample_strobe,
    input  logic                     i_delayed_valid,
    input  spike_delay_pkg::count_t  i_count_delayed
);

    timeunit 1ns;
    timeprecision 1ps;

    // failing property count
    int failure_count = 0;

    // sample strobe is a one cycle pulse
    strobe_single : assert property (@(posedge ep50trig) disable iff (reset_global)
        i_sample_strobe |=> !i_sample_strobe)
    else
    begin
        $error("sample strobe high for two cycles in a row");
        failure_count++;
    end

    // empty history slot must read as zero
    delayed_zero : assert property (@(posedge ep50trig) disable iff (reset_global)
        (i_sample_strobe && !i_delayed_valid) |-> (i_count_delayed == '0))
    else
    begin
        $error("delayed count nonzero while delayed valid is low");
        failure_count++;
    end

    // tick, clear and strobes all quiet in reset
    reset_quiet : assert property (@(posedge ep50trig)
        reset_global |-> !(i_sample_strobe || i_delayed_valid || i_sim_clear
                           || i_tick || i_count_strobe))
    else
    begin
        $error("control output active during reset");
        failure_count++;
    end

endmodule

bind spike_delay_top spike_delay_assertions u_spike_delay_assertions
(
    .ep50trig        (ep50trig),
    .reset_global    (reset_global),
    .i_sim_clear     (sim_clear),
    .i_tick          (tick),
    .i_count_strobe  (count_strobe),
    .i_sample_strobe (o_sample_strobe),
    .i_delayed_valid (o_delayed_valid),
    .i_count_delayed (o_count_delayed)
);

/* dv/spike_delay_tb.sv */
`include "spike_delay_macros.svh"

module spike_delay_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int BASE_ROWS        = 34;
    localparam int RAND_ROWS        = 40;
    localparam int ROWS             = BASE_ROWS + RAND_ROWS + 8;
    localparam int LONGEST_INTERVAL = 21;
    localparam int WATCHDOG_NS      = ROWS * (LONGEST_INTERVAL + 4) * 40 * 2;

    logic                     ep50trig;
    logic                     reset_global;
    logic                     i_cmd_strobe;
    spike_delay_pkg::cmd_op_t i_cmd_op;
    spike_delay_pkg::half_t   i_cmd_data;
    logic                     i_spike;
    spike_delay_pkg::count_t  o_count_now;
    spike_delay_pkg::count_t  o_count_delayed;
    logic                     o_delayed_valid;
    logic                     o_sample_strobe;

    // stimulus table, one entry per interval
    string                    row_name [$];
    spike_delay_pkg::cmd_op_t row_op [$];
    int                       row_data [$];
    int                       row_spikes [$];

    // reference model, counts sampled since the last clear
    int hist [$];
    int cur_half;
    int cycle_count = 0;
    int last_sample = 0;
    int error_count = 0;
    int row_errors;
    int tests_run = 0;
    int tests_failed = 0;

    spike_delay_top u_spike_delay_top
    (
        .ep50trig        (ep50trig),
        .reset_global    (reset_global),
        .i_cmd_strobe    (i_cmd_strobe),
        .i_cmd_op        (i_cmd_op),
        .i_cmd_data      (i_cmd_data),
        .i_spike         (i_spike),
        .o_count_now     (o_count_now),
        .o_count_delayed (o_count_delayed),
        .o_delayed_valid (o_delayed_valid),
        .o_sample_strobe (o_sample_strobe)
    );

    // 40 ns period
    always #20 ep50trig = ~ep50trig;

    // free running, gives strobe spacing
    always @(posedge ep50trig)
    begin
        cycle_count <= cycle_count + 1;
    end

    task automatic add_row(input string name, input spike_delay_pkg::cmd_op_t op,
                           input int data, input int spikes);
        row_name.push_back(name);
        row_op.push_back(op);
        row_data.push_back(data);
        row_spikes.push_back(spikes);
    endtask

    //////////////////////////////
    // stimulus table
    //////////////////////////////

    // spike counts fit the interval, 2n <= len - 6
    task automatic build_table();
        for (int k = 0; k < BASE_ROWS; k++)
        begin
            add_row($sformatf("base_%0d", k), spike_delay_pkg::CMD_NOP, 0, k % 3);
        end
        add_row("load_half_20", spike_delay_pkg::CMD_LOAD_HALF, 20, 1);
        add_row("slow_interval_a", spike_delay_pkg::CMD_NOP, 0, 5);
        add_row("slow_interval_b", spike_delay_pkg::CMD_NOP, 0, 7);
        add_row("sim_reset", spike_delay_pkg::CMD_SIM_RESET, 0, 3);
        for (int k = 0; k < RAND_ROWS; k++)
        begin
            add_row($sformatf("random_%0d", k), spike_delay_pkg::CMD_NOP, 0, $urandom % 7);
        end
        // clamped up to 3, no room left for spikes
        add_row("load_half_1", spike_delay_pkg::CMD_LOAD_HALF, 1, 2);
        for (int k = 0; k < 3; k++)
        begin
            add_row($sformatf("fast_interval_%0d", k), spike_delay_pkg::CMD_NOP, 0, 0);
        end
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        if (actual !== expected)
        begin
            $display("ERR %s %s expected %0d actual %0d", name, what, expected, actual);
            error_count++;
            row_errors++;
        end
    endtask

    // command one cycle, then spikes from the third cycle on
    task automatic drive_row(input int r);
        @(posedge ep50trig);
        i_cmd_strobe <= 1'b1;
        i_cmd_op     <= row_op[r];
        i_cmd_data   <= spike_delay_pkg::half_t'(row_data[r]);
        @(posedge ep50trig);
        i_cmd_strobe <= 1'b0;
        i_cmd_op     <= spike_delay_pkg::CMD_NOP;
        repeat (2) @(posedge ep50trig);
        repeat (row_spikes[r])
        begin
            i_spike <= 1'b1;
            @(posedge ep50trig);
            i_spike <= 1'b0;
            @(posedge ep50trig);
        end
    endtask

    // zero exp_gap skips the spacing check
    task automatic close_test(input string name, input int spikes, input int exp_gap);
        int gap;
        int exp_delayed;
        logic exp_valid;
        row_errors = 0;
        do
        begin
            @(negedge ep50trig);
        end
        while (!o_sample_strobe);
        gap = cycle_count - last_sample;
        last_sample = cycle_count;
        exp_valid = (hist.size() >= `SPK_HIST_DEPTH);
        exp_delayed = exp_valid ? hist[hist.size() - `SPK_HIST_DEPTH] : 0;
        if (exp_gap != 0)
        begin
            check_value(name, "spacing", exp_gap, gap);
        end
        check_value(name, "count_now", spikes, o_count_now);
        check_value(name, "count_delayed", exp_delayed, o_count_delayed);
        check_value(name, "delayed_valid", exp_valid, o_delayed_valid);
        hist.push_back(spikes);
        tests_run++;
        if (row_errors != 0)
        begin
            tests_failed++;
        end
        $display("%-20s %s", name, (row_errors == 0) ? "passed" : "failed");
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial
    begin
        int exp_gap;
        int asrt_fails;
        void'($urandom(81));
        ep50trig     = 1'b0;
        reset_global = 1'b1;
        i_cmd_strobe = 1'b0;
        i_cmd_op     = spike_delay_pkg::CMD_NOP;
        i_cmd_data   = '0;
        i_spike      = 1'b0;
        cur_half     = `SPK_HALF_DEFAULT;
        build_table();
        repeat (3) @(posedge ep50trig);
        reset_global <= 1'b0;
        // first interval after reset sees no spikes
        close_test("reset_interval", 0, 0);
        foreach (row_name[r])
        begin
            if (row_op[r] == spike_delay_pkg::CMD_SIM_RESET)
            begin
                // clear lands 2 cycles after the command, count restarts there
                exp_gap = cur_half + 6;
                hist.delete();
            end
            else
            begin
                exp_gap = cur_half + 1;
            end
            // load used from the next interval on
            if (row_op[r] == spike_delay_pkg::CMD_LOAD_HALF)
            begin
                cur_half = (row_data[r] < `SPK_HALF_MIN) ? `SPK_HALF_MIN : row_data[r];
            end
            drive_row(r);
            close_test(row_name[r], row_spikes[r], exp_gap);
        end
        asrt_fails = u_spike_delay_top.u_spike_delay_assertions.failure_count;
        if (asrt_fails != 0)
        begin
            $display("concurrent assertions failed %0d times", asrt_fails);
            error_count += asrt_fails;
        end
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0)
        begin
            $display("TEST OK");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog, sized from row count and longest interval
    initial
    begin
        #(WATCHDOG_NS);
        $display("sample strobe stopped, run did not finish within %0d ns", WATCHDOG_NS);
        $display("TEST FAILED");
        $finish;
    end

endmodule
